//--- hw/tile_pkg.sv
`default_nettype none

package tile_pkg;

  // Bus geometry
  localparam int unsigned ADDR_W     = 32;             // Request address width
  localparam int unsigned DATA_W     = 32;             // Word width
  localparam int unsigned BE_W       = DATA_W / 8;     // One enable per byte
  localparam int unsigned BYTE_OFF_W = $clog2(BE_W);   // Byte offset inside a word

  // L1 scratchpad geometry
  localparam int unsigned N_BANKS      = 4;                     // Word-interleaved banks
  localparam int unsigned N_WORDS_BANK = 256;                   // Rows per bank
  localparam int unsigned BANK_SEL_W   = $clog2(N_BANKS);       // Low word-address bits
  localparam int unsigned ROW_W        = $clog2(N_WORDS_BANK);  // Next word-address bits

  // Address map with inclusive bounds
  localparam logic [ADDR_W-1:0] L1_ADDR_START = 32'h1000_0000;  // 4 KiB scratchpad
  localparam logic [ADDR_W-1:0] L1_ADDR_END   = 32'h1000_0FFF;
  localparam logic [ADDR_W-1:0] L2_ADDR_START = 32'h8000_0000;  // External L2 window
  localparam logic [ADDR_W-1:0] L2_ADDR_END   = 32'h8FFF_FFFF;

  // Outstanding request limit that sizes every reorder queue
  localparam int unsigned FIFO_DEPTH = 8;

  // Where the response for an accepted request comes from
  typedef enum logic [1:0] {
    SRC_L1  = 2'd0,  // Banked scratchpad
    SRC_L2  = 2'd1,  // External L2 port
    SRC_ERR = 2'd2   // Unmapped address answered locally
  } rsp_src_e;

  typedef logic [DATA_W-1:0] data_t;  // One data word

endpackage

`default_nettype wire

//--- hw/mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;
  import tile_pkg::*;

  logic              valid;  // Single-cycle request strobe
  logic              we;     // Write when set, read otherwise
  logic [ADDR_W-1:0] addr;   // Byte address
  data_t             wdata;  // Write data
  logic [BE_W-1:0]   be;     // Byte enables for writes

  // Decoder side
  modport master (output valid, we, addr, wdata, be);

  // Scratchpad side
  modport slave (input valid, we, addr, wdata, be);

endinterface

`default_nettype wire

//--- hw/fifo_sync.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_sync #(
  parameter int unsigned DEPTH     = 8,     // Number of entries
  parameter type         payload_t = logic  // Entry type
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,   // Write data_i this cycle
  input  payload_t data_i,
  input  logic     pop_i,    // Drop the head this cycle
  output payload_t data_o,   // Head entry, valid when not empty
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // Storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;        // Entries held

  assign data_o  = mem_q[rd_ptr_q];  // Fall-through head
  assign empty_o = (count_q == '0);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;  // Wrap at DEPTH
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              tile_enable_i,
  input  logic                              req_valid_i,
  input  logic                              req_we_i,
  input  logic [tile_pkg::ADDR_W-1:0]       req_addr_i,
  input  tile_pkg::data_t                   req_wdata_i,
  input  logic [tile_pkg::BE_W-1:0]         req_be_i,
  mem_req_if.master                         l1_o,
  output logic                              l2_req_valid_o,
  output logic                              l2_req_we_o,
  output logic [tile_pkg::ADDR_W-1:0]       l2_req_addr_o,
  output tile_pkg::data_t                   l2_req_wdata_o,
  output logic [tile_pkg::BE_W-1:0]         l2_req_be_o,
  output logic                              ord_valid_o,
  output tile_pkg::rsp_src_e                ord_src_o
);
  import tile_pkg::*;

  logic              en_q;        // Registered tile enable
  logic              accept;      // Request taken this cycle
  logic              hit_l1;
  logic              hit_l2;
  rsp_src_e          src_d;       // Decoded target
  logic              l1_valid_q;
  logic              l2_valid_q;
  logic              we_q;        // Request fields shared by both targets
  logic [ADDR_W-1:0] addr_q;
  data_t             wdata_q;
  logic [BE_W-1:0]   be_q;

  assign accept = en_q && req_valid_i;  // Drop requests while disabled
  assign hit_l1 = (req_addr_i >= L1_ADDR_START) && (req_addr_i <= L1_ADDR_END);
  assign hit_l2 = (req_addr_i >= L2_ADDR_START) && (req_addr_i <= L2_ADDR_END);

  always_comb begin
    if (hit_l1) src_d = SRC_L1;
    else if (hit_l2) src_d = SRC_L2;
    else src_d = SRC_ERR;  // Neither region so rsp_merge answers it
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      en_q        <= 1'b0;
      l1_valid_q  <= 1'b0;
      l2_valid_q  <= 1'b0;
      ord_valid_o <= 1'b0;
    end else begin
      en_q        <= tile_enable_i;
      l1_valid_q  <= accept && (src_d == SRC_L1);  // At most one target strobes
      l2_valid_q  <= accept && (src_d == SRC_L2);
      ord_valid_o <= accept;                       // Every accepted request is ordered
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q      <= req_we_i;
      addr_q    <= req_addr_i;
      wdata_q   <= req_wdata_i;
      be_q      <= req_be_i;
      ord_src_o <= src_d;
    end
  end

  // L1 request
  assign l1_o.valid = l1_valid_q;
  assign l1_o.we    = we_q;
  assign l1_o.addr  = addr_q;
  assign l1_o.wdata = wdata_q;
  assign l1_o.be    = be_q;

  // L2 request
  assign l2_req_valid_o = l2_valid_q;
  assign l2_req_we_o    = we_q;
  assign l2_req_addr_o  = addr_q;
  assign l2_req_wdata_o = wdata_q;
  assign l2_req_be_o    = be_q;

endmodule

`default_nettype wire

//--- hw/l1_spm.sv
`timescale 1ns/10ps
`default_nettype none

module l1_spm (
  input  logic            clk_i,
  input  logic            rst_ni,
  mem_req_if.slave        req_i,
  output logic            rd_valid_o,  // One strobe per read or write request
  output tile_pkg::data_t rd_data_o    // Read word or zero after a write
);
  import tile_pkg::*;

  data_t                 mem [N_BANKS][N_WORDS_BANK];  // One array per bank
  logic [BANK_SEL_W-1:0] bank_sel;
  logic [ROW_W-1:0]      row_sel;

  // Consecutive words land in consecutive banks
  assign bank_sel = req_i.addr[BYTE_OFF_W +: BANK_SEL_W];
  assign row_sel  = req_i.addr[BYTE_OFF_W + BANK_SEL_W +: ROW_W];

  initial begin
    for (int b = 0; b < N_BANKS; b++) begin
      for (int r = 0; r < N_WORDS_BANK; r++) begin
        mem[b][r] = '0;  // Scratchpad starts cleared
      end
    end
  end

  // Byte-masked write port
  always @(posedge clk_i) begin
    if (req_i.valid && req_i.we) begin
      for (int i = 0; i < BE_W; i++) begin
        if (req_i.be[i]) begin
          mem[bank_sel][row_sel][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= req_i.valid;  // Result one cycle after the request
    end
  end

  // Registered read gives the old word when a write hits the same row
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        rd_data_o <= '0;  // Write acknowledge carries no data
      end else begin
        rd_data_o <= mem[bank_sel][row_sel];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rsp_merge.sv
`timescale 1ns/10ps
`default_nettype none

module rsp_merge (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ord_valid_i,     // One per accepted request
  input  tile_pkg::rsp_src_e ord_src_i,
  input  logic               l1_valid_i,      // L1 result strobe
  input  tile_pkg::data_t    l1_data_i,
  input  logic               l2_rsp_valid_i,  // L2 result strobe in L2 request order
  input  tile_pkg::data_t    l2_rsp_rdata_i,
  output logic               rsp_valid_o,
  output tile_pkg::data_t    rsp_rdata_o,
  output logic               rsp_err_o
);
  import tile_pkg::*;

  rsp_src_e ord_head;    // Source of the oldest open request
  logic     ord_empty;
  data_t    l1_head;
  logic     l1_empty;
  data_t    l2_head;
  logic     l2_empty;
  logic     head_rdy;    // Oldest request can retire now
  logic     pop_l1;
  logic     pop_l2;
  data_t    rsp_data_d;

  // Request order
  fifo_sync #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (rsp_src_e)
  ) i_ord_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (ord_valid_i),
    .data_i  (ord_src_i),
    .pop_i   (head_rdy),
    .data_o  (ord_head),
    .empty_o (ord_empty)
  );

  // Scratchpad results arrive in L1 order
  fifo_sync #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (data_t)
  ) i_l1_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (l1_valid_i),
    .data_i  (l1_data_i),
    .pop_i   (pop_l1),
    .data_o  (l1_head),
    .empty_o (l1_empty)
  );

  // L2 results with variable latency
  fifo_sync #(
    .DEPTH     (FIFO_DEPTH),
    .payload_t (data_t)
  ) i_l2_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (l2_rsp_valid_i),
    .data_i  (l2_rsp_rdata_i),
    .pop_i   (pop_l2),
    .data_o  (l2_head),
    .empty_o (l2_empty)
  );

  always_comb begin
    case (ord_head)
      SRC_L1: begin
        head_rdy   = !ord_empty && !l1_empty;  // Wait for the scratchpad word
        rsp_data_d = l1_head;
      end
      SRC_L2: begin
        head_rdy   = !ord_empty && !l2_empty;  // Wait for the L2 beat
        rsp_data_d = l2_head;
      end
      default: begin
        head_rdy   = !ord_empty;  // Error retires at once
        rsp_data_d = '0;
      end
    endcase
  end

  assign pop_l1 = head_rdy && (ord_head == SRC_L1);
  assign pop_l2 = head_rdy && (ord_head == SRC_L2);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= head_rdy;  // At most one response per cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (head_rdy) begin
      rsp_rdata_o <= rsp_data_d;
      rsp_err_o   <= (ord_head == SRC_ERR);
    end
  end

endmodule

`default_nettype wire

//--- hw/mem_tile.sv
`timescale 1ns/10ps
`default_nettype none

module mem_tile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        tile_enable_i,   // Takes effect one cycle later

  // Request port from the requester
  input  logic                        req_valid_i,
  input  logic                        req_we_i,
  input  logic [tile_pkg::ADDR_W-1:0] req_addr_i,
  input  tile_pkg::data_t             req_wdata_i,
  input  logic [tile_pkg::BE_W-1:0]   req_be_i,

  // Response port in request order
  output logic                        rsp_valid_o,
  output tile_pkg::data_t             rsp_rdata_o,
  output logic                        rsp_err_o,

  // External L2 request port
  output logic                        l2_req_valid_o,
  output logic                        l2_req_we_o,
  output logic [tile_pkg::ADDR_W-1:0] l2_req_addr_o,
  output tile_pkg::data_t             l2_req_wdata_o,
  output logic [tile_pkg::BE_W-1:0]   l2_req_be_o,

  // L2 response strobe
  input  logic                        l2_rsp_valid_i,
  input  tile_pkg::data_t             l2_rsp_rdata_i
);
  import tile_pkg::*;

  logic     ord_valid;  // Order strobe from decoder to merge
  rsp_src_e ord_src;
  logic     rd_valid;   // Scratchpad result
  data_t    rd_data;

  mem_req_if l1_req ();  // Decoder to scratchpad

  addr_decoder i_addr_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tile_enable_i  (tile_enable_i),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .req_be_i       (req_be_i),
    .l1_o           (l1_req.master),
    .l2_req_valid_o (l2_req_valid_o),
    .l2_req_we_o    (l2_req_we_o),
    .l2_req_addr_o  (l2_req_addr_o),
    .l2_req_wdata_o (l2_req_wdata_o),
    .l2_req_be_o    (l2_req_be_o),
    .ord_valid_o    (ord_valid),
    .ord_src_o      (ord_src)
  );

  l1_spm i_l1_spm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (l1_req.slave),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data)
  );

  rsp_merge i_rsp_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ord_valid_i    (ord_valid),
    .ord_src_i      (ord_src),
    .l1_valid_i     (rd_valid),
    .l1_data_i      (rd_data),
    .l2_rsp_valid_i (l2_rsp_valid_i),
    .l2_rsp_rdata_i (l2_rsp_rdata_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_err_o      (rsp_err_o)
  );

endmodule

`default_nettype wire

//--- verification/tb_mem_tile.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_tile;
  import tile_pkg::*;

  localparam int SEED_INIT  = 85;
  localparam int WAIT_LIMIT = 400;  // Cycles allowed for any single wait
  localparam int L2_DLY_MIN = 1;    // L2 responder latency range in cycles
  localparam int L2_DLY_MAX = 6;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    data_t             wdata;
    logic [BE_W-1:0]   be;
  } l2_req_t;

  logic              clk_i;
  logic              rst_ni;
  logic              tile_enable_i;
  logic              req_valid_i;
  logic              req_we_i;
  logic [ADDR_W-1:0] req_addr_i;
  data_t             req_wdata_i;
  logic [BE_W-1:0]   req_be_i;
  logic              rsp_valid_o;
  data_t             rsp_rdata_o;
  logic              rsp_err_o;
  logic              l2_req_valid_o;
  logic              l2_req_we_o;
  logic [ADDR_W-1:0] l2_req_addr_o;
  data_t             l2_req_wdata_o;
  logic [BE_W-1:0]   l2_req_be_o;
  logic              l2_rsp_valid_i = 1'b0;  // Driven by the L2 model
  data_t             l2_rsp_rdata_i = '0;

  integer  seed;         // Stimulus
  integer  dly_seed;     // L2 latency kept apart from stimulus
  int      cycle    = 0;
  int      err_cnt  = 0;
  int      pass_cnt = 0;
  int      fail_cnt = 0;
  int      rsp_cnt  = 0;  // Responses seen
  int      l2_cnt   = 0;  // L2 requests seen
  int      l2_last  = 0;  // Due cycle of the newest L2 answer
  bit      timed_out = 1'b0;
  data_t   ref_mem [1024];  // L1 reference with one entry per word
  data_t   exp_data_q [$];  // Expected responses in request order
  logic    exp_err_q [$];
  l2_req_t l2_exp_q [$];   // L2 requests the stimulus sent
  int      l2_due_q [$];   // Pending L2 answers
  data_t   l2_dat_q [$];

  mem_tile UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    err_cnt++;
    $display("Timeout while waiting for %s", what);
  endtask

  // L2 responder and response checker sample at the falling edge
  always @(negedge clk_i) begin
    l2_req_t exp_req;
    int      due;
    cycle++;
    if (l2_req_valid_o) begin
      l2_cnt++;
      assert (l2_exp_q.size() != 0) else begin
        err_cnt++;
        $display("L2 request issued although none was expected");
      end
      if (l2_exp_q.size() != 0) begin
        exp_req = l2_exp_q.pop_front();
        check_val("l2_req_we_o", 32'(l2_req_we_o), 32'(exp_req.we));
        check_val("l2_req_addr_o", l2_req_addr_o, exp_req.addr);
        check_val("l2_req_wdata_o", l2_req_wdata_o, exp_req.wdata);
        check_val("l2_req_be_o", 32'(l2_req_be_o), 32'(exp_req.be));
      end
      due = cycle + L2_DLY_MIN
          + int'($unsigned($random(dly_seed)) % (L2_DLY_MAX - L2_DLY_MIN + 1));
      if (due <= l2_last) due = l2_last + 1;  // Answers stay in order
      l2_last = due;
      l2_due_q.push_back(due);
      l2_dat_q.push_back(l2_req_we_o ? '0 : (l2_req_addr_o ^ 32'hA5A5_A5A5));
    end
    if (l2_due_q.size() != 0 && l2_due_q[0] <= cycle) begin
      l2_rsp_valid_i = 1'b1;
      l2_rsp_rdata_i = l2_dat_q.pop_front();
      void'(l2_due_q.pop_front());
    end else begin
      l2_rsp_valid_i = 1'b0;
      l2_rsp_rdata_i = '0;
    end
    if (rsp_valid_o) begin
      rsp_cnt++;
      assert (exp_data_q.size() != 0) else begin
        err_cnt++;
        $display("Response arrived with no request outstanding");
      end
      if (exp_data_q.size() != 0) begin
        check_val("rsp_rdata_o", rsp_rdata_o, exp_data_q.pop_front());
        check_val("rsp_err_o", 32'(rsp_err_o), 32'(exp_err_q.pop_front()));
      end
    end
  end

  function automatic logic [ADDR_W-1:0] pick_addr(input int region);
    logic [31:0] r;
    r = $unsigned($random(seed));
    if (region == 0) return L1_ADDR_START + (r & 32'h0000_0FFC);
    if (region == 1) return L2_ADDR_START + (r & 32'h0FFF_FFFC);
    return 32'h4000_0000 + (r & 32'h00FF_FFFC);  // Outside both regions
  endfunction

  task automatic drive_req(input logic we, input logic [ADDR_W-1:0] addr, input data_t wdata,
                           input logic [BE_W-1:0] be);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Predicts the response from the address map and then sends the request
  task automatic issue(input logic we, input logic [ADDR_W-1:0] addr, input data_t wdata,
                       input logic [BE_W-1:0] be);
    int      n;
    int      w;
    l2_req_t l2_req;
    n = 0;
    while (exp_data_q.size() >= FIFO_DEPTH && !timed_out) begin  // Outstanding limit
      @(negedge clk_i);
      n++;
      if (n >= WAIT_LIMIT) note_timeout("a free request slot");
    end
    if (addr >= L1_ADDR_START && addr <= L1_ADDR_END) begin
      w = int'((addr - L1_ADDR_START) >> 2);
      exp_data_q.push_back(we ? '0 : ref_mem[w]);
      exp_err_q.push_back(1'b0);
      for (int i = 0; i < BE_W; i++) begin
        if (we && be[i]) ref_mem[w][8*i +: 8] = wdata[8*i +: 8];
      end
    end else if (addr >= L2_ADDR_START && addr <= L2_ADDR_END) begin
      l2_req.we    = we;
      l2_req.addr  = addr;
      l2_req.wdata = wdata;
      l2_req.be    = be;
      l2_exp_q.push_back(l2_req);
      exp_data_q.push_back(we ? '0 : (addr ^ 32'hA5A5_A5A5));
      exp_err_q.push_back(1'b0);
    end else begin
      exp_data_q.push_back('0);
      exp_err_q.push_back(1'b1);
    end
    drive_req(we, addr, wdata, be);
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && !timed_out) begin
      @(negedge clk_i);
      n++;
      if (n >= WAIT_LIMIT) note_timeout(what);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s, %0d errors", name, err_cnt - err_before);
    end
  endtask

  task automatic run_tests();
    int e;
    logic [ADDR_W-1:0] a;
    // Idle after reset, then requests while the tile is disabled
    e = err_cnt;
    check_val("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_val("l2_req_valid_o", 32'(l2_req_valid_o), 32'h0);
    drive_req(1'b0, L1_ADDR_START + 32'h40, '0, '0);
    drive_req(1'b1, L2_ADDR_START + 32'h80, 32'h1234_5678, 4'hF);
    repeat (10) @(negedge clk_i);  // Window in which nothing may come back
    check_val("response count", 32'(rsp_cnt), 32'h0);
    check_val("L2 request count", 32'(l2_cnt), 32'h0);
    tile_enable_i = 1'b1;
    repeat (3) @(negedge clk_i);
    finish_test("reset and disabled tile", e);
    // Byte-enable merge on L1
    e = err_cnt;
    for (int i = 0; i < 8; i++) begin
      a = pick_addr(0);
      issue(1'b1, a, $random(seed), 4'hF);
      issue(1'b1, a, $random(seed), BE_W'($random(seed)));
      issue(1'b0, a, $random(seed), '0);
    end
    drain("L1 write and read responses");
    finish_test("L1 byte-enable write then read", e);
    // Sixteen words cover every bank four times
    e = err_cnt;
    for (int i = 0; i < 16; i++) begin
      issue(1'b1, L1_ADDR_START + 32'(32'h100 + 4 * i), $random(seed), 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, L1_ADDR_START + 32'(32'h100 + 4 * i), '0, '0);
    end
    drain("bank interleave responses");
    finish_test("bank interleave", e);
    e = err_cnt;
    for (int i = 0; i < 8; i++) issue(i[0], pick_addr(1), $random(seed), BE_W'($random(seed)));
    drain("L2 responses");
    finish_test("L2 forwarding", e);
    e = err_cnt;
    for (int i = 0; i < 48; i++) begin
      issue(1'($random(seed)), pick_addr(int'($unsigned($random(seed)) % 3)), $random(seed),
            BE_W'($random(seed)));
    end
    drain("mixed sequence responses");
    finish_test("mixed ordering", e);
    // The word just past the L1 end shares its bank and row bits with the first L1 word
    e = err_cnt;
    a = L1_ADDR_END + 32'h1;
    issue(1'b1, L1_ADDR_START, 32'hCAFE_F00D, 4'hF);
    drain("L1 setup write");
    begin
      int l2_before;
      l2_before = l2_cnt;
      issue(1'b1, a, 32'hDEAD_BEEF, 4'hF);
      issue(1'b0, L1_ADDR_START - 32'h4, '0, '0);
      issue(1'b0, L1_ADDR_START, '0, '0);
      drain("unmapped responses");
      check_val("L2 request count", 32'(l2_cnt), 32'(l2_before));
    end
    finish_test("unmapped address", e);
  endtask

  initial begin
    seed          = SEED_INIT;
    dly_seed      = SEED_INIT;
    rst_ni        = 1'b0;
    tile_enable_i = 1'b0;
    req_valid_i   = 1'b0;
    req_we_i      = 1'b0;
    req_addr_i    = '0;
    req_wdata_i   = '0;
    req_be_i      = '0;
    for (int i = 0; i < 1024; i++) ref_mem[i] = '0;  // Scratchpad starts cleared
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    run_tests();
    $display("Tests: %0d passed, %0d failed, %0d check errors", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/tile_pkg.sv
hw/mem_req_if.sv
hw/fifo_sync.sv
hw/addr_decoder.sv
hw/l1_spm.sv
hw/rsp_merge.sv
hw/mem_tile.sv
verification/tb_mem_tile.sv

//--- run_sim.sh
#!/bin/sh
# Builds the mem_tile testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_tile -Mdir obj_dir -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_mem_tile > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
